/* compile.f */
logic/coreParamsPkg.sv
logic/isaPkg.sv
logic/aluDecoder.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/intAlu.sv
logic/scalarCore.sv
verif/tbClock.sv
verif/scalarCoreTb.sv

/* Bender.yml */
package:
  name: scalar_core

sources:
  - logic/coreParamsPkg.sv
  - logic/isaPkg.sv
  - logic/aluDecoder.sv
  - logic/instrDecoder.sv
  - logic/regFile.sv
  - logic/intAlu.sv
  - logic/scalarCore.sv
  - target: simulation
    files:
      - verif/tbClock.sv
      - verif/scalarCoreTb.sv

/* verif/scalarCoreTb.sv */
// Testbench for the scalar integer core.
// Directed tests drive instructions one at a time and compare every result
// against a model of the register file and the NZCV flags.
`timescale 1ns/1ps
`default_nettype none

module scalarCoreTb
    import coreParamsPkg::*;
    import isaPkg::*;
();

    logic    clk;
    logic    rst;
    logic    instValid;
    instrT   instr;
    logic    resultValid;
    dataT    result;
    regAddrT resultRd;
    flagsT   flags;
    logic    branchTaken;
    logic    illegal;

    dataT       mRegs [RegCount];                  // model register file.
    logic [3:0] mFlags;                             // model flags in n, z, c, v order.
    integer     seed;
    instrT      burst [$];                          // instructions issued on consecutive cycles.

    tbClock tbClock_inst (
        .clk (clk),
        .rst (rst)
    );

    scalarCore scalarCore_inst (
        .clk         (clk),
        .rst         (rst),
        .instValid   (instValid),
        .instr       (instr),
        .resultValid (resultValid),
        .result      (result),
        .resultRd    (resultRd),
        .flags       (flags),
        .branchTaken (branchTaken),
        .illegal     (illegal)
    );

    function automatic instrT regOp(input logic [2:0] fn, input regAddrT rd,
                                    input regAddrT rs1, input regAddrT rs2);
        return {ScalarArith, rd, rs1, rs2, 1'b0, fn};
    endfunction

    function automatic instrT immOp(input logic [1:0] s, input regAddrT rd,
                                    input regAddrT rs1, input logic [4:0] imm);
        return {ScalarImm, rd, rs1, s, imm};
    endfunction

    function automatic instrT branchOp(input logic [1:0] cond, input regAddrT rs1,
                                       input regAddrT rs2);
        return {Branch, cond, 1'b0, rs1, rs2, 4'b0000};
    endfunction

    // picks one of r1 to r6. r7 is kept as the shift amount.
    function automatic regAddrT randReg();
        return regAddrT'(1 + {$random(seed)} % 6);
    endfunction

    task automatic expectEq(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] time %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // applies the instruction set rules to the model and returns what the core must show.
    task automatic predict(input instrT ins, output dataT res, output logic bad,
                           output logic taken);
        logic [2:0] op;
        logic [2:0] fn;
        regAddrT    rd;
        dataT       a;
        dataT       b;
        aluOpE      kind;
        logic       c;
        logic       v;
        logic       n;
        logic       z;
        int         sa;
        int         sb;
        op    = ins[15:13];
        fn    = ins[2:0];
        rd    = ins[12:10];
        a     = mRegs[ins[9:7]];
        b     = mRegs[ins[6:4]];
        kind  = AluAdd;
        bad   = 1'b1;
        taken = 1'b0;
        res   = '0;
        c     = 1'b0;
        v     = 1'b0;
        if (op == ScalarArith && (fn <= 3'b011 || fn == 3'b111)) begin
            bad  = 1'b0;
            kind = aluOpE'(fn);                     // function codes match the ALU codes.
        end else if (op == ScalarImm && ins[6:5] != 2'b11) begin
            bad  = 1'b0;
            kind = aluOpE'({1'b0, ins[6:5]});
            b    = {{(DataWidth-5){ins[4]}}, ins[4:0]};
        end else if (op == Branch) begin
            bad  = 1'b0;
            kind = AluSub;
        end
        if (!bad) begin
            sa = $signed(a);
            sb = $signed(b);
            case (kind)
                AluAdd: begin
                    {c, res} = {1'b0, a} + {1'b0, b};
                    v = (sa + sb > 32767) || (sa + sb < -32768);
                end
                AluSub: begin
                    res = a - b;
                    c   = (a >= b);                 // no borrow.
                    v   = (sa - sb > 32767) || (sa - sb < -32768);
                end
                AluMul:  res = a * b;
                AluSll:  res = a << b[3:0];
                default: res = a >> b[3:0];
            endcase
            n = res[DataWidth-1];
            z = (res == '0);
            mFlags = {n, z, c, v};
            if (op == Branch) begin
                case (ins[12:11])
                    2'b00:   taken = z;
                    2'b01:   taken = !z;
                    2'b10:   taken = n ^ v;
                    default: taken = 1'b1;
                endcase
            end else if (rd != '0) begin
                mRegs[rd] = res;
            end
        end
    endtask

    // compares the outputs of one finished instruction with the model's prediction.
    task automatic checkOutputs(input instrT ins, input dataT expRes, input logic expBad,
                                input logic expTaken, input logic [3:0] expFlags);
        expectEq("illegal", illegal, expBad);
        expectEq("branchTaken", branchTaken, expTaken);
        expectEq("flags", flags, expFlags);
        if (!expBad) begin
            expectEq("result", result, expRes);
        end
        if (!expBad && ins[15:13] != Branch) begin
            expectEq("resultRd", resultRd, ins[12:10]);
        end
    endtask

    task automatic checkIdle();
        assert (resultValid === 1'b0) else begin
            $display("resultValid stayed high for more than one cycle at %0t", $time);
            $display("sim failed");
            $fatal(1, "long resultValid");
        end
    endtask

    // issues one instruction, waits for its result and checks every output.
    task automatic runInstr(input instrT ins);
        dataT expRes;
        logic expBad;
        logic expTaken;
        int   cycles;
        predict(ins, expRes, expBad, expTaken);
        instr     = ins;
        instValid = 1'b1;
        @(posedge clk);
        #1;
        instValid = 1'b0;
        cycles    = 0;
        while (resultValid !== 1'b1) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 20) begin
                $display("resultValid never arrived for instruction %h", ins);
                $display("sim failed");
                $fatal(1, "timeout");
            end
        end
        checkOutputs(ins, expRes, expBad, expTaken, mFlags);
        @(posedge clk);
        #1;
        checkIdle();
    endtask

    // issues the queued instructions back to back and checks the results in order.
    task automatic runBurst();
        dataT       expRes   [32];
        logic       expBad   [32];
        logic       expTaken [32];
        logic [3:0] expFlags [32];
        int         issued;
        int         checked;
        int         idle;
        issued  = 0;
        checked = 0;
        idle    = 0;
        while (checked < burst.size()) begin
            if (issued < burst.size()) begin
                predict(burst[issued], expRes[issued], expBad[issued], expTaken[issued]);
                expFlags[issued] = mFlags;
                instr     = burst[issued];
                instValid = 1'b1;
                issued++;
            end else begin
                instValid = 1'b0;
            end
            @(posedge clk);
            #1;
            if (resultValid === 1'b1) begin
                checkOutputs(burst[checked], expRes[checked], expBad[checked],
                             expTaken[checked], expFlags[checked]);
                checked++;
                idle = 0;
            end else begin
                idle++;
                if (idle > 20) begin
                    $display("resultValid never arrived for burst entry %0d", checked);
                    $display("sim failed");
                    $fatal(1, "timeout");
                end
            end
        end
        instValid = 1'b0;
        @(posedge clk);
        #1;
        checkIdle();
        burst.delete();
    endtask

    // reads r1 to r7 through an add into r0, which compares them with the model.
    task automatic checkRegs();
        int r;
        for (r = 1; r < RegCount; r++) begin
            runInstr(regOp(3'b000, 3'd0, regAddrT'(r), 3'd0));
        end
    endtask

    task automatic loadRandom(input regAddrT rd);
        runInstr(immOp(2'b00, rd, 3'd0, 5'($random(seed))));
        repeat (2) begin
            runInstr(regOp(3'b011, rd, rd, 3'd7));  // shift left by r7.
            runInstr(immOp(2'b00, rd, rd, 5'($random(seed))));
        end
    endtask

    task automatic afterReset();
        int i;
        for (i = 0; i < 3; i++) begin
            expectEq("resultValid", resultValid, 1'b0);
            expectEq("branchTaken", branchTaken, 1'b0);
            expectEq("illegal", illegal, 1'b0);
            expectEq("flags", flags, 4'h0);
            @(posedge clk);
            #1;
        end
        runInstr(immOp(2'b00, 3'd1, 3'd0, 5'b11011));
        expectEq("result", result, 16'hfffb);       // -5 sign-extended.
    endtask

    task automatic immTests();
        int i;
        runInstr(immOp(2'b00, 3'd7, 3'd0, 5'd5));
        for (i = 1; i < 7; i++) begin
            loadRandom(regAddrT'(i));
        end
        for (i = 0; i < 12; i++) begin
            runInstr(immOp(2'(i % 3), randReg(), randReg(), 5'($random(seed))));
        end
    endtask

    task automatic regTests();
        logic [2:0] funcs [5];
        regAddrT    prevRd;
        regAddrT    rd;
        int         i;
        funcs  = '{3'b000, 3'b001, 3'b010, 3'b011, 3'b111};
        prevRd = randReg();
        for (i = 0; i < 15; i++) begin
            rd = randReg();
            burst.push_back(regOp(funcs[i % 5], rd, prevRd, randReg()));  // reads the last result.
            prevRd = rd;
        end
        runBurst();
    endtask

    task automatic zeroRegTests();
        runInstr(regOp(3'b000, 3'd0, 3'd1, 3'd2));
        runInstr(immOp(2'b00, 3'd0, 3'd3, 5'd9));
        runInstr(regOp(3'b000, 3'd4, 3'd0, 3'd0));
        expectEq("result", result, 16'h0000);
    endtask

    task automatic branchTests();
        int c;
        runInstr(immOp(2'b00, 3'd1, 3'd0, 5'd6));
        runInstr(regOp(3'b000, 3'd2, 3'd1, 3'd0));
        runInstr(immOp(2'b00, 3'd3, 3'd0, 5'd11));
        runInstr(immOp(2'b00, 3'd4, 3'd0, 5'b11101));
        for (c = 0; c < 4; c++) begin
            runInstr(branchOp(2'(c), 3'd1, 3'd2));  // equal.
            runInstr(branchOp(2'(c), 3'd1, 3'd3));
            runInstr(branchOp(2'(c), 3'd3, 3'd1));
            runInstr(branchOp(2'(c), 3'd4, 3'd1));  // signed less, unsigned greater.
        end
        checkRegs();
    endtask

    task automatic illegalTests();
        // a negative difference leaves n and c set, which an add of the operands would clear.
        runInstr(regOp(3'b001, 3'd0, 3'd4, 3'd1));
        runInstr(regOp(3'b100, 3'd1, 3'd2, 3'd3));
        runInstr(regOp(3'b101, 3'd2, 3'd3, 3'd4));
        runInstr(regOp(3'b110, 3'd3, 3'd4, 3'd5));
        runInstr({VectorArith, 13'h0a5b});
        runInstr(immOp(2'b11, 3'd1, 3'd2, 5'd3));
        runInstr({3'b111, 13'h1234});
        runInstr({3'b011, 13'h0f0f});
        checkRegs();
    endtask

    initial begin
        int cycles;
        int r;
        seed      = 33396;
        instValid = 1'b0;
        instr     = '0;
        mFlags    = '0;
        for (r = 0; r < RegCount; r++) begin
            mRegs[r] = '0;
        end
        cycles = 0;
        @(posedge clk);
        while (rst !== 1'b0) begin
            @(posedge clk);
            cycles++;
            if (cycles > 10) begin
                $display("reset was never released");
                $display("sim failed");
                $fatal(1, "reset stuck");
            end
        end
        #1;
        afterReset();
        immTests();
        regTests();
        zeroRegTests();
        branchTests();
        illegalTests();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/tbClock.sv */
// Testbench clock and reset source.
// A 40 ns clock with reset held high for the first two rising edges.
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;                              // released like every other input.
    end

endmodule

`default_nettype wire

/* logic/scalarCore.sv */
// Scalar integer core top level.
// Chains the instruction decoder, the register file and the integer ALU.
`timescale 1ns/1ps
`default_nettype none

module scalarCore
    import coreParamsPkg::*;
    import isaPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    instValid,
    input  instrT   instr,
    output logic    resultValid,
    output dataT    result,
    output regAddrT resultRd,
    output flagsT   flags,
    output logic    branchTaken,
    output logic    illegal
);

    decodedT dec;
    dataT    rdData1;
    dataT    rdData2;
    logic    wrEn;
    regAddrT wrAddr;
    dataT    wrData;

    instrDecoder instrDecoder_inst (
        .clk       (clk),
        .rst       (rst),
        .instValid (instValid),
        .instr     (instr),
        .dec       (dec)
    );

    // operands are read during the cycle the bundle is valid.
    regFile regFile_inst (
        .clk     (clk),
        .rst     (rst),
        .rdAddr1 (dec.rs1),
        .rdAddr2 (dec.rs2),
        .rdData1 (rdData1),
        .rdData2 (rdData2),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData)
    );

    intAlu intAlu_inst (
        .clk         (clk),
        .rst         (rst),
        .dec         (dec),
        .opA         (rdData1),
        .opB         (rdData2),
        .wrEn        (wrEn),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .resultValid (resultValid),
        .result      (result),
        .resultRd    (resultRd),
        .flags       (flags),
        .branchTaken (branchTaken),
        .illegal     (illegal)
    );

endmodule

`default_nettype wire

/* logic/intAlu.sv */
// Integer ALU.
// Computes add, sub, mul and shifts with NZCV flags, evaluates branch conditions
// and registers the result, flags and register write-back.
`timescale 1ns/1ps
`default_nettype none

module intAlu
    import coreParamsPkg::*;
    import isaPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  decodedT dec,
    input  dataT    opA,
    input  dataT    opB,
    output logic    wrEn,
    output regAddrT wrAddr,
    output dataT    wrData,
    output logic    resultValid,
    output dataT    result,
    output regAddrT resultRd,
    output flagsT   flags,
    output logic    branchTaken,
    output logic    illegal
);

    dataT               secondOp;
    dataT               aluRes;
    logic [DataWidth:0] wideSum;
    logic               carryOut;
    logic               overflow;
    flagsT              newFlags;
    logic               condMet;
    logic               exec;

    assign secondOp = dec.useImm ? dec.imm : opB;
    assign exec     = dec.valid && !dec.illegal;

    always_comb begin
        wideSum  = '0;
        aluRes   = '0;
        carryOut = 1'b0;                            // mul and shifts leave c and v clear.
        overflow = 1'b0;
        case (dec.aluOp)
            AluAdd: begin
                wideSum  = {1'b0, opA} + {1'b0, secondOp};
                aluRes   = wideSum[DataWidth-1:0];
                carryOut = wideSum[DataWidth];
                overflow = (opA[DataWidth-1] == secondOp[DataWidth-1]) &&
                           (aluRes[DataWidth-1] != opA[DataWidth-1]);
            end
            AluSub: begin
                // c is set when no borrow occurs, i.e. opA >= secondOp unsigned.
                wideSum  = {1'b0, opA} + {1'b0, ~secondOp} + 1'b1;
                aluRes   = wideSum[DataWidth-1:0];
                carryOut = wideSum[DataWidth];
                overflow = (opA[DataWidth-1] != secondOp[DataWidth-1]) &&
                           (aluRes[DataWidth-1] != opA[DataWidth-1]);
            end
            AluMul:  aluRes = opA * secondOp;       // low half of the product.
            AluSll:  aluRes = opA << secondOp[ShiftWidth-1:0];
            AluSrl:  aluRes = opA >> secondOp[ShiftWidth-1:0];
            default: aluRes = '0;
        endcase
    end

    assign newFlags = '{n: aluRes[DataWidth-1], z: (aluRes == '0), c: carryOut, v: overflow};

    // branches test the flags of their own subtraction.
    always_comb begin
        case (dec.cond)
            CondEq:  condMet = newFlags.z;
            CondNe:  condMet = !newFlags.z;
            CondLt:  condMet = newFlags.n ^ newFlags.v;
            default: condMet = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
            branchTaken <= 1'b0;
            illegal     <= 1'b0;
            flags       <= '0;
        end else begin
            resultValid <= dec.valid;
            illegal     <= dec.valid && dec.illegal;
            branchTaken <= exec && dec.isBranch && condMet;
            if (exec) begin
                flags <= newFlags;                  // illegal instructions keep the old flags.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid) begin
            result   <= aluRes;
            resultRd <= dec.rd;
        end
    end

    // write-back lands in the register file at the same edge the result appears.
    assign wrEn   = exec && dec.regWrite;
    assign wrAddr = dec.rd;
    assign wrData = aluRes;

endmodule

`default_nettype wire

/* logic/regFile.sv */
// Register file with two asynchronous read ports and one synchronous write port.
// Register 0 always reads as zero.
`timescale 1ns/1ps
`default_nettype none

module regFile
    import coreParamsPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  regAddrT rdAddr1,
    input  regAddrT rdAddr2,
    output dataT    rdData1,
    output dataT    rdData2,
    input  logic    wrEn,
    input  regAddrT wrAddr,
    input  dataT    wrData
);

    dataT regs [RegCount];

    // reads bypass nothing, so a value written at an edge is visible right after it.
    assign rdData1 = (rdAddr1 == '0) ? '0 : regs[rdAddr1];
    assign rdData2 = (rdAddr2 == '0) ? '0 : regs[rdAddr2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

`default_nettype wire

/* logic/instrDecoder.sv */
// Instruction decoder.
// Splits the instruction into its fields, sign-extends the immediate and
// registers the resulting control bundle once per cycle.
`timescale 1ns/1ps
`default_nettype none

module instrDecoder
    import coreParamsPkg::*;
    import isaPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    instValid,
    input  instrT   instr,
    output decodedT dec
);

    instrRegT regForm;
    instrImmT immForm;
    aluOpE    aluOp;
    logic     legal;
    decodedT  decNext;

    // both views share the opcode and the rd and rs1 positions.
    assign regForm = instrRegT'(instr);
    assign immForm = instrImmT'(instr);

    aluDecoder aluDecoder_inst (
        .opcode (regForm.opcode),
        .func   (regForm.func),
        .size   (immForm.size),
        .aluOp  (aluOp),
        .legal  (legal)
    );

    always_comb begin
        decNext.valid    = instValid;
        decNext.aluOp    = aluOp;
        decNext.useImm   = (regForm.opcode == ScalarImm);
        decNext.imm      = {{(DataWidth-ImmWidth){immForm.imm[ImmWidth-1]}}, immForm.imm};
        decNext.rd       = regForm.rd;
        decNext.rs1      = regForm.rs1;
        decNext.rs2      = regForm.rs2;

        // a write to r0 is dropped here already.
        decNext.regWrite = legal && (regForm.opcode != Branch) && (regForm.rd != '0);
        decNext.isBranch = legal && (regForm.opcode == Branch);
        decNext.cond     = condE'(instr[CondHi:CondLo]);
        decNext.illegal  = !legal;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec <= '0;
        end else begin
            dec <= decNext;                         // valid simply follows the strobe.
        end
    end

endmodule

`default_nettype wire

/* logic/aluDecoder.sv */
// ALU decoder.
// Maps opcode, function and size fields to an integer ALU operation and flags
// the encodings this core does not execute as illegal.
`timescale 1ns/1ps
`default_nettype none

module aluDecoder
    import isaPkg::*;
(
    input  opcodeE     opcode,
    input  logic [2:0] func,
    input  logic [1:0] size,
    output aluOpE      aluOp,
    output logic       legal
);

    always_comb begin
        // anything not matched below stays an illegal add.
        aluOp = AluAdd;
        legal = 1'b0;

        case (opcode)
            ScalarArith: begin
                case (func)
                    3'b000: begin
                        aluOp = AluAdd;
                        legal = 1'b1;
                    end
                    3'b001: begin
                        aluOp = AluSub;
                        legal = 1'b1;
                    end
                    3'b010: begin
                        aluOp = AluMul;
                        legal = 1'b1;
                    end
                    3'b011: begin
                        aluOp = AluSll;
                        legal = 1'b1;
                    end
                    3'b111: begin
                        aluOp = AluSrl;
                        legal = 1'b1;
                    end
                    default: legal = 1'b0;          // 100 to 110 are the floating-point ops.
                endcase
            end

            ScalarImm: begin
                case (size)
                    2'b00: aluOp = AluAdd;
                    2'b01: aluOp = AluSub;
                    2'b10: aluOp = AluMul;
                    default: aluOp = AluAdd;
                endcase
                legal = (size != 2'b11);
            end

            // branches subtract so that the flags describe the comparison.
            Branch: begin
                aluOp = AluSub;
                legal = 1'b1;
            end

            // the vector datapath is not part of this core.
            VectorArith: legal = 1'b0;

            default: legal = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/isaPkg.sv */
// Instruction set definitions for the scalar integer core.
// Opcode, ALU operation and branch condition encodings, the instruction layouts,
// and the decoded control bundle and flag structs.
`default_nettype none

package isaPkg;

    import coreParamsPkg::*;

    localparam int ImmWidth = 5;                    // signed immediate in the immediate form.

    // the branch condition lives in the top two bits of the rd field.
    localparam int CondHi = 12;
    localparam int CondLo = 11;

    typedef enum logic [2:0] {
        ScalarArith = 3'b000,
        VectorArith = 3'b001,
        ScalarImm   = 3'b010,
        Branch      = 3'b110
    } opcodeE;

    typedef enum logic [2:0] {
        AluAdd = 3'b000,
        AluSub = 3'b001,
        AluMul = 3'b010,
        AluSll = 3'b011,
        AluSrl = 3'b111
    } aluOpE;

    typedef enum logic [1:0] {
        CondEq     = 2'b00,
        CondNe     = 2'b01,
        CondLt     = 2'b10,
        CondAlways = 2'b11
    } condE;

    // register form, also used for the opcode and register fields of every other form.
    typedef struct packed {
        opcodeE  opcode;
        regAddrT rd;
        regAddrT rs1;
        regAddrT rs2;
        logic    spare;                             // bit 3 is not decoded.
        logic [2:0] func;
    } instrRegT;

    typedef struct packed {
        opcodeE  opcode;
        regAddrT rd;
        regAddrT rs1;
        logic [1:0] size;                           // selects add, sub or mul.
        logic [ImmWidth-1:0] imm;
    } instrImmT;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flagsT;

    // control bundle handed from the decoder to the register file and the ALU.
    typedef struct packed {
        logic    valid;
        aluOpE   aluOp;
        logic    useImm;
        dataT    imm;
        regAddrT rd;
        regAddrT rs1;
        regAddrT rs2;
        logic    regWrite;
        logic    isBranch;
        condE    cond;
        logic    illegal;
    } decodedT;

endpackage

`default_nettype wire

/* logic/coreParamsPkg.sv */
// Core parameters for the scalar integer core.
// Holds the datapath and register file sizes and the vector types built on them.
`default_nettype none

package coreParamsPkg;

    localparam int DataWidth    = 16;              // width of operands and results.
    localparam int RegCount     = 8;
    localparam int RegAddrWidth = $clog2(RegCount);
    localparam int InstrWidth   = 16;

    // shift amounts only need enough bits to cover the data width.
    localparam int ShiftWidth   = $clog2(DataWidth);

    // operands, results and register contents.
    typedef logic [DataWidth-1:0] dataT;

    typedef logic [RegAddrWidth-1:0] regAddrT;     // register index.

    typedef logic [InstrWidth-1:0] instrT;         // raw instruction word.

endpackage

`default_nettype wire
